// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = csr_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/csr_pkg.sv
design/csr_access.sv
design/csr_trap_ctrl.sv
design/csr_regfile.sv
design/csr_commit.sv
design/csr_top.sv
verif/csr_tb.sv

// File: design/csr_access.sv
`timescale 1ns/1ps

module csr_access (
  input  logic                csr_cmd_v_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::xword_t     csr_data_i,
  input  csr_pkg::xword_t     csr_rdata_i,
  input  csr_pkg::priv_e      priv_mode_i,
  input  logic [1:0]          mcounteren_i,
  output csr_pkg::xword_t     csr_wdata_o,
  output logic                csr_wr_en_o,
  output logic                csr_illegal_o,
  output logic                csr_known_o
);

  import csr_pkg::*;

  xword_t csr_imm;
  logic   is_csr_op;
  logic   is_mret;
  logic   priv_fail;
  logic   counter_fail;

  // Immediate forms carry a zero-extended 5-bit value
  assign csr_imm   = XLEN'(csr_data_i[4:0]);
  assign is_csr_op = csr_op_i inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                      OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
  assign is_mret   = csr_op_i == OP_MRET;

  always_comb
  begin
    case (csr_op_i)
      OP_CSRRW:  csr_wdata_o = csr_data_i;
      OP_CSRRS:  csr_wdata_o = csr_data_i | csr_rdata_i;
      OP_CSRRC:  csr_wdata_o = ~csr_data_i & csr_rdata_i;
      OP_CSRRWI: csr_wdata_o = csr_imm;
      OP_CSRRSI: csr_wdata_o = csr_imm | csr_rdata_i;
      OP_CSRRCI: csr_wdata_o = ~csr_imm & csr_rdata_i;
      default:   csr_wdata_o = csr_rdata_i;
    endcase
  end

  always_comb
  begin
    case (csr_addr_i)
      ADDR_CYCLE, ADDR_INSTRET, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID,
      ADDR_MSTATUS, ADDR_MISA, ADDR_MTVEC, ADDR_MCOUNTEREN, ADDR_MSCRATCH,
      ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MCYCLE, ADDR_MINSTRET:
        csr_known_o = 1'b1;
      default:
        csr_known_o = 1'b0;
    endcase
  end

  always_comb
  begin
    priv_fail     = priv_mode_i < csr_addr_i[9:8];
    // Counter reads from U mode need the matching enable
    counter_fail  = (priv_mode_i == PRIV_U)
                  & (((csr_addr_i == ADDR_CYCLE) & ~mcounteren_i[0])
                  | ((csr_addr_i == ADDR_INSTRET) & ~mcounteren_i[1]));
    csr_illegal_o = csr_cmd_v_i
                  & ((is_csr_op & (priv_fail | ~csr_known_o | counter_fail))
                  | (is_mret & (priv_mode_i != PRIV_M)));
    csr_wr_en_o   = csr_cmd_v_i & is_csr_op & ~csr_illegal_o;
  end

endmodule

// File: design/csr_commit.sv
`timescale 1ns/1ps

module csr_commit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        trap_v_i,
  input  logic                        ret_v_i,
  input  logic                        instret_i,
  input  logic [csr_pkg::VADDR_W-3:0] mtvec_base_i,
  input  csr_pkg::vaddr_t             mepc_i,
  input  csr_pkg::vaddr_t             exception_npc_i,
  output csr_pkg::vaddr_t             apc_o,
  output csr_pkg::vaddr_t             npc_o,
  output logic                        npc_w_v_o
);

  import csr_pkg::*;

  vaddr_t apc_r;
  vaddr_t apc_n;

  // Trap beats return, return beats a plain retire
  always_comb
  begin
    if (trap_v_i)
      apc_n = {mtvec_base_i, 2'b00};
    else if (ret_v_i)
      apc_n = mepc_i;
    else if (instret_i)
      apc_n = exception_npc_i;
    else
      apc_n = apc_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      apc_r <= BOOT_PC;
    else
      apc_r <= apc_n;
  end

  assign apc_o     = apc_r;
  assign npc_o     = apc_n;
  assign npc_w_v_o = trap_v_i | ret_v_i;

endmodule

// File: design/csr_pkg.sv
package csr_pkg;

  localparam int XLEN    = 64;
  localparam int VADDR_W = 39;

  typedef logic [XLEN-1:0]    xword_t;
  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [11:0]        csr_addr_t;

  localparam vaddr_t BOOT_PC = VADDR_W'(32'h8000_0000);

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  typedef enum logic [3:0] {
    OP_CSRRW  = 4'd0,
    OP_CSRRS  = 4'd1,
    OP_CSRRC  = 4'd2,
    OP_CSRRWI = 4'd3,
    OP_CSRRSI = 4'd4,
    OP_CSRRCI = 4'd5,
    OP_MRET   = 4'd6
  } csr_op_e;

  // User counters, aliases of the machine counters
  localparam csr_addr_t ADDR_CYCLE      = 12'hC00;
  localparam csr_addr_t ADDR_INSTRET    = 12'hC02;
  localparam csr_addr_t ADDR_MVENDORID  = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID    = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID     = 12'hF13;
  localparam csr_addr_t ADDR_MSTATUS    = 12'h300;
  localparam csr_addr_t ADDR_MISA       = 12'h301;
  localparam csr_addr_t ADDR_MTVEC      = 12'h305;
  localparam csr_addr_t ADDR_MCOUNTEREN = 12'h306;
  localparam csr_addr_t ADDR_MSCRATCH   = 12'h340;
  localparam csr_addr_t ADDR_MEPC       = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE     = 12'h342;
  localparam csr_addr_t ADDR_MTVAL      = 12'h343;
  localparam csr_addr_t ADDR_MCYCLE     = 12'hB00;
  localparam csr_addr_t ADDR_MINSTRET   = 12'hB02;

  localparam xword_t MARCHID_VAL = 64'd13;
  localparam xword_t MIMPID_VAL  = 64'd1;
  // MXL of 2 with the I and U extensions
  localparam xword_t MISA_VAL    = {2'b10, 36'b0, 26'h010_0100};

  localparam logic [3:0] CAUSE_ILLEGAL        = 4'd2;
  localparam logic [3:0] CAUSE_BREAK          = 4'd3;
  localparam logic [3:0] CAUSE_LOAD_MISALIGN  = 4'd4;
  localparam logic [3:0] CAUSE_STORE_MISALIGN = 4'd6;
  localparam logic [3:0] CAUSE_ECALL_U        = 4'd8;
  localparam logic [3:0] CAUSE_ECALL_M        = 4'd11;

  typedef struct packed {
    logic illegal;
    logic ebreak;
    logic load_misalign;
    logic store_misalign;
    logic ecall;
  } exc_flags_t;

endpackage

// File: design/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  csr_pkg::csr_addr_t          csr_addr_i,
  input  logic                        csr_wr_en_i,
  input  csr_pkg::xword_t             csr_wdata_i,
  input  logic                        trap_v_i,
  input  logic [3:0]                  trap_cause_i,
  input  csr_pkg::xword_t             trap_tval_i,
  input  logic                        ret_v_i,
  input  logic                        instret_i,
  input  csr_pkg::vaddr_t             apc_i,
  input  csr_pkg::priv_e              priv_mode_i,
  output csr_pkg::xword_t             csr_rdata_o,
  output logic                        mstatus_mpp_m_o,
  output logic [csr_pkg::VADDR_W-3:0] mtvec_base_o,
  output csr_pkg::vaddr_t             mepc_o,
  output logic [1:0]                  mcounteren_o
);

  import csr_pkg::*;

  logic               mie_r;
  logic               mpie_r;
  logic               mpp_m_r;
  logic [VADDR_W-3:0] mtvec_base_r;
  logic [1:0]         mcounteren_r;
  xword_t             mscratch_r;
  vaddr_t             mepc_r;
  xword_t             mcause_r;
  xword_t             mtval_r;
  xword_t             mcycle_r;
  xword_t             minstret_r;
  xword_t             mstatus_rd;
  logic               wr_mcycle;
  logic               wr_minstret;

  assign wr_mcycle   = csr_wr_en_i & (csr_addr_i inside {ADDR_MCYCLE, ADDR_CYCLE});
  assign wr_minstret = csr_wr_en_i & (csr_addr_i inside {ADDR_MINSTRET, ADDR_INSTRET});

  // Only mie, mpie and mpp exist; mpp reads as 11 or 00
  assign mstatus_rd = XLEN'({mpp_m_r, mpp_m_r, 3'b000, mpie_r, 3'b000, mie_r, 3'b000});

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mie_r        <= 1'b0;
      mpie_r       <= 1'b0;
      mpp_m_r      <= 1'b0;
      mtvec_base_r <= '0;
      mcounteren_r <= '0;
      mscratch_r   <= '0;
      mepc_r       <= '0;
      mcause_r     <= '0;
      mtval_r      <= '0;
      mcycle_r     <= '0;
      minstret_r   <= '0;
    end
    else
    begin
      mcycle_r   <= wr_mcycle ? csr_wdata_i : mcycle_r + XLEN'(1);
      minstret_r <= wr_minstret ? csr_wdata_i : minstret_r + XLEN'(instret_i);
      if (csr_wr_en_i)
      begin
        case (csr_addr_i)
          ADDR_MSTATUS:
          begin
            mie_r   <= csr_wdata_i[3];
            mpie_r  <= csr_wdata_i[7];
            mpp_m_r <= &csr_wdata_i[12:11];
          end
          ADDR_MTVEC:      mtvec_base_r <= csr_wdata_i[VADDR_W-1:2];
          ADDR_MCOUNTEREN: mcounteren_r <= {csr_wdata_i[2], csr_wdata_i[0]};
          ADDR_MSCRATCH:   mscratch_r   <= csr_wdata_i;
          ADDR_MEPC:       mepc_r       <= csr_wdata_i[VADDR_W-1:0];
          ADDR_MCAUSE:     mcause_r     <= csr_wdata_i;
          ADDR_MTVAL:      mtval_r      <= csr_wdata_i;
          default: ;
        endcase
      end
      if (trap_v_i)
      begin
        mepc_r   <= apc_i;
        mcause_r <= XLEN'(trap_cause_i);
        mtval_r  <= trap_tval_i;
        mpie_r   <= mie_r;
        mie_r    <= 1'b0;
        mpp_m_r  <= priv_mode_i == PRIV_M;
      end
      else if (ret_v_i)
      begin
        mie_r   <= mpie_r;
        mpie_r  <= 1'b1;
        mpp_m_r <= 1'b0;
      end
    end
  end

  always_comb
  begin
    case (csr_addr_i)
      ADDR_CYCLE, ADDR_MCYCLE:     csr_rdata_o = mcycle_r;
      ADDR_INSTRET, ADDR_MINSTRET: csr_rdata_o = minstret_r;
      ADDR_MVENDORID:              csr_rdata_o = '0;
      ADDR_MARCHID:                csr_rdata_o = MARCHID_VAL;
      ADDR_MIMPID:                 csr_rdata_o = MIMPID_VAL;
      ADDR_MSTATUS:                csr_rdata_o = mstatus_rd;
      ADDR_MISA:                   csr_rdata_o = MISA_VAL;
      ADDR_MTVEC:                  csr_rdata_o = XLEN'({mtvec_base_r, 2'b00});
      ADDR_MCOUNTEREN:             csr_rdata_o = XLEN'({mcounteren_r[1], 1'b0, mcounteren_r[0]});
      ADDR_MSCRATCH:               csr_rdata_o = mscratch_r;
      ADDR_MEPC:                   csr_rdata_o = XLEN'($signed(mepc_r));
      ADDR_MCAUSE:                 csr_rdata_o = mcause_r;
      ADDR_MTVAL:                  csr_rdata_o = mtval_r;
      default:                     csr_rdata_o = '0;
    endcase
  end

  assign mstatus_mpp_m_o = mpp_m_r;
  assign mtvec_base_o    = mtvec_base_r;
  assign mepc_o          = mepc_r;
  assign mcounteren_o    = mcounteren_r;

  // A trapping instruction never updates a CSR
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(csr_wr_en_i && trap_v_i))
    else $error("csr_regfile: CSR write coincides with a trap");

endmodule

// File: design/csr_top.sv
`timescale 1ns/1ps

module csr_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 csr_cmd_v_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  csr_pkg::csr_addr_t   csr_addr_i,
  input  csr_pkg::xword_t      csr_data_i,
  input  logic                 exception_v_i,
  input  csr_pkg::exc_flags_t  exc_flags_i,
  input  csr_pkg::vaddr_t      exception_npc_i,
  input  csr_pkg::vaddr_t      exception_vaddr_i,
  input  logic [31:0]          exception_instr_i,
  output csr_pkg::xword_t      csr_data_o,
  output logic                 trap_v_o,
  output logic                 ret_v_o,
  output logic                 npc_w_v_o,
  output csr_pkg::vaddr_t      npc_o,
  output csr_pkg::vaddr_t      pc_o,
  output logic                 instret_o,
  output csr_pkg::priv_e       priv_mode_o
);

  import csr_pkg::*;

  xword_t             csr_rdata;
  xword_t             csr_wdata;
  logic               csr_wr_en;
  logic               csr_illegal;
  logic               csr_known;
  logic [1:0]         mcounteren;
  logic [3:0]         trap_cause;
  xword_t             trap_tval;
  logic               mstatus_mpp_m;
  logic [VADDR_W-3:0] mtvec_base;
  vaddr_t             mepc;

  csr_access access_i (
    .csr_cmd_v_i   (csr_cmd_v_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .csr_data_i    (csr_data_i),
    .csr_rdata_i   (csr_rdata),
    .priv_mode_i   (priv_mode_o),
    .mcounteren_i  (mcounteren),
    .csr_wdata_o   (csr_wdata),
    .csr_wr_en_o   (csr_wr_en),
    .csr_illegal_o (csr_illegal),
    .csr_known_o   (csr_known)
  );

  csr_trap_ctrl trap_ctrl_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .csr_cmd_v_i       (csr_cmd_v_i),
    .csr_op_i          (csr_op_i),
    .csr_illegal_i     (csr_illegal),
    .exception_v_i     (exception_v_i),
    .exc_flags_i       (exc_flags_i),
    .exception_vaddr_i (exception_vaddr_i),
    .exception_instr_i (exception_instr_i),
    .mstatus_mpp_m_i   (mstatus_mpp_m),
    .trap_v_o          (trap_v_o),
    .trap_cause_o      (trap_cause),
    .trap_tval_o       (trap_tval),
    .ret_v_o           (ret_v_o),
    .instret_o         (instret_o),
    .priv_mode_o       (priv_mode_o)
  );

  csr_regfile regfile_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wr_en_i     (csr_wr_en),
    .csr_wdata_i     (csr_wdata),
    .trap_v_i        (trap_v_o),
    .trap_cause_i    (trap_cause),
    .trap_tval_i     (trap_tval),
    .ret_v_i         (ret_v_o),
    .instret_i       (instret_o),
    .apc_i           (pc_o),
    .priv_mode_i     (priv_mode_o),
    .csr_rdata_o     (csr_rdata),
    .mstatus_mpp_m_o (mstatus_mpp_m),
    .mtvec_base_o    (mtvec_base),
    .mepc_o          (mepc),
    .mcounteren_o    (mcounteren)
  );

  csr_commit commit_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .trap_v_i        (trap_v_o),
    .ret_v_i         (ret_v_o),
    .instret_i       (instret_o),
    .mtvec_base_i    (mtvec_base),
    .mepc_i          (mepc),
    .exception_npc_i (exception_npc_i),
    .apc_o           (pc_o),
    .npc_o           (npc_o),
    .npc_w_v_o       (npc_w_v_o)
  );

  // Old value goes back only on a legal access
  assign csr_data_o = (csr_known & ~csr_illegal) ? csr_rdata : '0;

endmodule

// File: design/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 csr_cmd_v_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic                 csr_illegal_i,
  input  logic                 exception_v_i,
  input  csr_pkg::exc_flags_t  exc_flags_i,
  input  csr_pkg::vaddr_t      exception_vaddr_i,
  input  logic [31:0]          exception_instr_i,
  input  logic                 mstatus_mpp_m_i,
  output logic                 trap_v_o,
  output logic [3:0]           trap_cause_o,
  output csr_pkg::xword_t      trap_tval_o,
  output logic                 ret_v_o,
  output logic                 instret_o,
  output csr_pkg::priv_e       priv_mode_o
);

  import csr_pkg::*;

  logic [15:0] cause_vec;
  logic [3:0]  cause_sel;
  logic        is_m;
  priv_e       priv_mode_r;

  assign is_m = priv_mode_r == PRIV_M;

  always_comb
  begin
    cause_vec                       = '0;
    cause_vec[CAUSE_ILLEGAL]        = exc_flags_i.illegal | csr_illegal_i;
    cause_vec[CAUSE_BREAK]          = exc_flags_i.ebreak;
    cause_vec[CAUSE_LOAD_MISALIGN]  = exc_flags_i.load_misalign;
    cause_vec[CAUSE_STORE_MISALIGN] = exc_flags_i.store_misalign;
    cause_vec[CAUSE_ECALL_U]        = exc_flags_i.ecall & ~is_m;
    cause_vec[CAUSE_ECALL_M]        = exc_flags_i.ecall & is_m;
  end

  // Lowest set code wins, so scan from the top down
  always_comb
  begin
    cause_sel = '0;
    for (int i = 15; i >= 0; i--)
    begin
      if (cause_vec[i])
        cause_sel = 4'(i);
    end
  end

  assign trap_v_o     = exception_v_i & (|cause_vec);
  assign trap_cause_o = cause_sel;
  assign trap_tval_o  = (cause_sel == CAUSE_ILLEGAL) ? XLEN'(exception_instr_i)
                                                     : XLEN'($signed(exception_vaddr_i));
  assign ret_v_o      = csr_cmd_v_i & (csr_op_i == OP_MRET) & is_m;
  assign instret_o    = exception_v_i & ~trap_v_o;
  assign priv_mode_o  = priv_mode_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      priv_mode_r <= PRIV_M;
    end
    else if (trap_v_o)
    begin
      priv_mode_r <= PRIV_M;
    end
    else if (ret_v_o)
    begin
      priv_mode_r <= mstatus_mpp_m_i ? PRIV_M : PRIV_U;
    end
  end

  // An mret must not arrive with exception flags attached
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(trap_v_o && ret_v_o))
    else $error("csr_trap_ctrl: trap and mret in the same cycle");

endmodule

// File: verif/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;

  import csr_pkg::*;

  logic       clk_i;
  logic       rst_n_i;
  logic       csr_cmd_v_i;
  csr_op_e    csr_op_i;
  csr_addr_t  csr_addr_i;
  xword_t     csr_data_i;
  logic       exception_v_i;
  exc_flags_t exc_flags_i;
  vaddr_t     exception_npc_i;
  vaddr_t     exception_vaddr_i;
  logic [31:0] exception_instr_i;
  xword_t     csr_data_o;
  logic       trap_v_o;
  logic       ret_v_o;
  logic       npc_w_v_o;
  vaddr_t     npc_o;
  vaddr_t     pc_o;
  logic       instret_o;
  priv_e      priv_mode_o;

  // Reference state, holds the DUT registers of the current cycle
  priv_e              m_priv;
  vaddr_t             m_pc;
  vaddr_t             m_mepc;
  xword_t             m_mscratch;
  xword_t             m_mcause;
  xword_t             m_mtval;
  xword_t             m_mcycle;
  xword_t             m_minstret;
  logic [VADDR_W-3:0] m_mtvec_base;
  logic [1:0]         m_cen;
  logic               m_mie;
  logic               m_mpie;
  logic               m_mpp_m;

  xword_t  e_data;
  logic    e_trap;
  logic    e_ret;
  logic    e_instret;
  vaddr_t  e_npc;
  integer  seed;
  csr_op_e rand_op;
  int      num_checks;

  csr_top dut_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .csr_cmd_v_i       (csr_cmd_v_i),
    .csr_op_i          (csr_op_i),
    .csr_addr_i        (csr_addr_i),
    .csr_data_i        (csr_data_i),
    .exception_v_i     (exception_v_i),
    .exc_flags_i       (exc_flags_i),
    .exception_npc_i   (exception_npc_i),
    .exception_vaddr_i (exception_vaddr_i),
    .exception_instr_i (exception_instr_i),
    .csr_data_o        (csr_data_o),
    .trap_v_o          (trap_v_o),
    .ret_v_o           (ret_v_o),
    .npc_w_v_o         (npc_w_v_o),
    .npc_o             (npc_o),
    .pc_o              (pc_o),
    .instret_o         (instret_o),
    .priv_mode_o       (priv_mode_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic compare_word(input string name, input xword_t got, input xword_t exp);
    num_checks++;
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic verify_bit(input string name, input logic got, input logic exp);
    num_checks++;
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_priv(input string name, input priv_e got, input priv_e exp);
    num_checks++;
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic match_pc(input string name, input vaddr_t got, input vaddr_t exp);
    num_checks++;
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  function automatic xword_t ref_read(input csr_addr_t addr);
    case (addr)
      ADDR_CYCLE, ADDR_MCYCLE:     return m_mcycle;
      ADDR_INSTRET, ADDR_MINSTRET: return m_minstret;
      ADDR_MARCHID:                return MARCHID_VAL;
      ADDR_MIMPID:                 return MIMPID_VAL;
      ADDR_MISA:                   return MISA_VAL;
      ADDR_MSTATUS:                return (xword_t'(m_mie) << 3) | (xword_t'(m_mpie) << 7)
                                        | (m_mpp_m ? 64'h1800 : 64'h0);
      ADDR_MTVEC:                  return {{(XLEN-VADDR_W){1'b0}}, m_mtvec_base, 2'b00};
      ADDR_MCOUNTEREN:             return {61'b0, m_cen[1], 1'b0, m_cen[0]};
      ADDR_MSCRATCH:               return m_mscratch;
      ADDR_MEPC:                   return {{(XLEN-VADDR_W){m_mepc[VADDR_W-1]}}, m_mepc};
      ADDR_MCAUSE:                 return m_mcause;
      ADDR_MTVAL:                  return m_mtval;
      default:                     return '0;
    endcase
  endfunction

  // Expected outputs for the current inputs, then advance the state by one edge
  function automatic void model_step(output xword_t d, output logic trap, output logic ret,
                                     output logic ins, output vaddr_t npc);
    xword_t     old_val;
    xword_t     opnd;
    xword_t     wval;
    xword_t     tval;
    logic       known;
    logic       illegal;
    logic       wr;
    logic [3:0] cause;
    known   = csr_addr_i inside {ADDR_CYCLE, ADDR_INSTRET, ADDR_MVENDORID, ADDR_MARCHID,
                                 ADDR_MIMPID, ADDR_MSTATUS, ADDR_MISA, ADDR_MTVEC,
                                 ADDR_MCOUNTEREN, ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE,
                                 ADDR_MTVAL, ADDR_MCYCLE, ADDR_MINSTRET};
    old_val = ref_read(csr_addr_i);
    opnd    = (csr_op_i inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI})
            ? {59'b0, csr_data_i[4:0]} : csr_data_i;
    case (csr_op_i)
      OP_CSRRS, OP_CSRRSI: wval = old_val | opnd;
      OP_CSRRC, OP_CSRRCI: wval = old_val & ~opnd;
      default:             wval = opnd;
    endcase
    if (csr_op_i == OP_MRET)
      illegal = csr_cmd_v_i && m_priv != PRIV_M;
    else
      illegal = csr_cmd_v_i && (csr_addr_i[9:8] > m_priv || !known
                || (m_priv == PRIV_U && ((csr_addr_i == ADDR_CYCLE && !m_cen[0])
                || (csr_addr_i == ADDR_INSTRET && !m_cen[1]))));
    wr = csr_cmd_v_i && csr_op_i != OP_MRET && !illegal;
    if (exc_flags_i.illegal || illegal) cause = 4'd2;
    else if (exc_flags_i.ebreak) cause = 4'd3;
    else if (exc_flags_i.load_misalign) cause = 4'd4;
    else if (exc_flags_i.store_misalign) cause = 4'd6;
    else if (exc_flags_i.ecall) cause = (m_priv == PRIV_M) ? 4'd11 : 4'd8;
    else cause = 4'd0;
    trap = exception_v_i && cause != 4'd0;
    ret  = csr_cmd_v_i && csr_op_i == OP_MRET && m_priv == PRIV_M;
    ins  = exception_v_i && !trap;
    d    = (known && !illegal) ? old_val : '0;
    tval = (cause == 4'd2) ? {32'b0, exception_instr_i}
         : {{(XLEN-VADDR_W){exception_vaddr_i[VADDR_W-1]}}, exception_vaddr_i};
    if (trap) npc = {m_mtvec_base, 2'b00};
    else if (ret) npc = m_mepc;
    else if (ins) npc = exception_npc_i;
    else npc = m_pc;
    m_mcycle   = m_mcycle + 64'd1;
    m_minstret = m_minstret + {63'b0, ins};
    if (wr)
    begin
      case (csr_addr_i)
        ADDR_MSTATUS:
        begin
          m_mie   = wval[3];
          m_mpie  = wval[7];
          m_mpp_m = &wval[12:11];
        end
        ADDR_MTVEC:                  m_mtvec_base = wval[VADDR_W-1:2];
        ADDR_MCOUNTEREN:             m_cen = {wval[2], wval[0]};
        ADDR_MSCRATCH:               m_mscratch = wval;
        ADDR_MEPC:                   m_mepc = wval[VADDR_W-1:0];
        ADDR_MCAUSE:                 m_mcause = wval;
        ADDR_MTVAL:                  m_mtval = wval;
        ADDR_CYCLE, ADDR_MCYCLE:     m_mcycle = wval;
        ADDR_INSTRET, ADDR_MINSTRET: m_minstret = wval;
        default: ;
      endcase
    end
    if (trap)
    begin
      m_mepc   = m_pc;
      m_mcause = {60'b0, cause};
      m_mtval  = tval;
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mpp_m  = m_priv == PRIV_M;
      m_priv   = PRIV_M;
    end
    else if (ret)
    begin
      m_priv  = m_mpp_m ? PRIV_M : PRIV_U;
      m_mie   = m_mpie;
      m_mpie  = 1'b1;
      m_mpp_m = 1'b0;
    end
    m_pc = npc;
  endfunction

  task automatic reset_model();
    m_priv       = PRIV_M;
    m_pc         = BOOT_PC;
    m_mepc       = '0;
    m_mscratch   = '0;
    m_mcause     = '0;
    m_mtval      = '0;
    m_mcycle     = '0;
    m_minstret   = '0;
    m_mtvec_base = '0;
    m_cen        = '0;
    m_mie        = 1'b0;
    m_mpie       = 1'b0;
    m_mpp_m      = 1'b0;
  endtask

  // Outputs are settled mid-cycle, inputs change only on the rising edge
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
      reset_model();
    else
    begin
      check_priv("priv_mode_o", priv_mode_o, m_priv);
      match_pc("pc_o", pc_o, m_pc);
      model_step(e_data, e_trap, e_ret, e_instret, e_npc);
      compare_word("csr_data_o", csr_data_o, e_data);
      verify_bit("trap_v_o", trap_v_o, e_trap);
      verify_bit("ret_v_o", ret_v_o, e_ret);
      verify_bit("instret_o", instret_o, e_instret);
      verify_bit("npc_w_v_o", npc_w_v_o, e_trap | e_ret);
      match_pc("npc_o", npc_o, e_npc);
    end
  end

  task automatic drive(input logic cmd, input csr_op_e op, input csr_addr_t addr,
                       input xword_t data, input logic exc, input exc_flags_t flags,
                       input vaddr_t vaddr);
    @(posedge clk_i);
    csr_cmd_v_i       <= cmd;
    csr_op_i          <= op;
    csr_addr_i        <= addr;
    csr_data_i        <= data;
    exception_v_i     <= exc;
    exc_flags_i       <= flags;
    exception_vaddr_i <= vaddr;
    exception_npc_i   <= m_pc + 39'd4;
    exception_instr_i <= {addr, 20'h02073};
    @(negedge clk_i);
  endtask

  task automatic run_csr(input csr_op_e op, input csr_addr_t addr, input xword_t data);
    drive(1'b1, op, addr, data, 1'b1, '0, '0);
  endtask

  task automatic retire(input exc_flags_t flags, input vaddr_t vaddr);
    drive(1'b0, OP_CSRRW, '0, '0, 1'b1, flags, vaddr);
  endtask

  task automatic issue_mret();
    drive(1'b1, OP_MRET, '0, '0, 1'b1, '0, '0);
  endtask

  task automatic idle();
    drive(1'b0, OP_CSRRW, '0, '0, 1'b0, '0, '0);
  endtask

  task automatic wait_priv(input priv_e want);
    int waited;
    waited = 0;
    while (priv_mode_o !== want)
    begin
      if (waited == 8)
      begin
        $display("Privilege mode did not reach %s within 8 cycles", want.name());
        $display("Test failed");
        $fatal(1);
      end
      idle();
      waited++;
    end
  endtask

  task automatic enter_user();
    run_csr(OP_CSRRC, ADDR_MSTATUS, 64'h1800);
    issue_mret();
    wait_priv(PRIV_U);
  endtask

  initial
  begin
    seed              = 32'hc15a5639;
    num_checks        = 0;
    rst_n_i           = 1'b0;
    csr_cmd_v_i       = 1'b0;
    csr_op_i          = OP_CSRRW;
    csr_addr_i        = '0;
    csr_data_i        = '0;
    exception_v_i     = 1'b0;
    exc_flags_i       = '0;
    exception_npc_i   = '0;
    exception_vaddr_i = '0;
    exception_instr_i = '0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    run_csr(OP_CSRRS, ADDR_MCYCLE, '0);
    run_csr(OP_CSRRW, ADDR_MTVEC, 64'h8000_1003);
    for (int i = 0; i < 24; i++)
    begin
      rand_op = csr_op_e'(4'($unsigned($random(seed)) % 6));
      run_csr(rand_op, ADDR_MSCRATCH, {$random(seed), $random(seed)});
      run_csr(OP_CSRRS, ADDR_MSCRATCH, '0);
    end
    run_csr(OP_CSRRS, ADDR_MVENDORID, '0);
    run_csr(OP_CSRRS, ADDR_MARCHID, '0);
    run_csr(OP_CSRRS, ADDR_MIMPID, '0);
    run_csr(OP_CSRRS, ADDR_MISA, '0);
    // Unused address
    run_csr(OP_CSRRW, 12'h7C0, 64'h55);
    run_csr(OP_CSRRS, ADDR_MCAUSE, '0);
    run_csr(OP_CSRRS, ADDR_MTVAL, '0);
    retire(exc_flags_t'(5'b00001), '0);
    run_csr(OP_CSRRS, ADDR_MEPC, '0);
    enter_user();
    retire(exc_flags_t'(5'b00001), '0);
    wait_priv(PRIV_M);
    run_csr(OP_CSRRS, ADDR_MSTATUS, '0);
    run_csr(OP_CSRRS, ADDR_MCAUSE, '0);
    enter_user();
    run_csr(OP_CSRRW, ADDR_MSCRATCH, 64'h1234);
    wait_priv(PRIV_M);
    enter_user();
    run_csr(OP_CSRRS, ADDR_CYCLE, '0);
    wait_priv(PRIV_M);
    enter_user();
    issue_mret();
    wait_priv(PRIV_M);
    run_csr(OP_CSRRW, ADDR_MCOUNTEREN, 64'h5);
    enter_user();
    run_csr(OP_CSRRS, ADDR_CYCLE, '0);
    run_csr(OP_CSRRS, ADDR_INSTRET, '0);
    retire(exc_flags_t'(5'b00001), '0);
    wait_priv(PRIV_M);
    // Load misaligned alone, then together with ecall
    retire(exc_flags_t'(5'b00100), 39'h40_0000_1234);
    run_csr(OP_CSRRS, ADDR_MTVAL, '0);
    retire(exc_flags_t'(5'b00101), 39'h42);
    run_csr(OP_CSRRS, ADDR_MCAUSE, '0);
    retire(exc_flags_t'(5'b00000), '0);
    idle();
    idle();
    run_csr(OP_CSRRS, ADDR_MCYCLE, '0);
    run_csr(OP_CSRRS, ADDR_MINSTRET, '0);
    idle();
    @(posedge clk_i);
    if (num_checks == 0)
    begin
      $display("No comparisons were made during the run");
      $display("Test failed");
      $fatal(1);
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
